// ==== flist.f ====
rtl/movegen_pkg.sv
rtl/movegen_board_load.sv
rtl/movegen_piece_stack.sv
rtl/movegen_leaper_targets.sv
rtl/movegen_dest_scan.sv
rtl/movegen_uci_out.sv
rtl/movegen_top.sv
test/movegen_props.sv
test/movegen_tb.sv

// ==== rtl/movegen_board_load.sv ====
module movegen_board_load (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_pos_valid,
  input  logic                  i_pos_sop,
  input  movegen_pkg::pos_data_t i_pos_data,
  output movegen_pkg::square_t   o_square,
  output movegen_pkg::board_t    o_board
);

  // index of the next square expected on the serial load
  movegen_pkg::square_t square_q;

  // board copy, one four bit code per square
  movegen_pkg::board_t board_q;

  logic restart;

  // a start of packet always lands on a1, whatever the counter says
  assign restart = i_pos_valid & i_pos_sop;

  // the square of the code on the bus this cycle
  assign o_square = restart ? movegen_pkg::square_t'(0) : square_q;

  // count the squares as they arrive
  // the counter wraps from h8 back to a1 on its own after 64 squares
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      square_q <= '0;
    end else if (i_pos_valid) begin
      square_q <= movegen_pkg::square_t'(o_square + 1'b1);
    end
  end

  // store every code into its slot of the board copy
  // empty squares are written too so a reload overwrites the old position
  always_ff @(posedge clk) begin
    if (i_pos_valid) begin
      board_q[{o_square, 2'b00} +: 4] <= i_pos_data;
    end
  end

  // the board copy feeds the own piece check and the takes lookup
  assign o_board = board_q;

endmodule

// ==== rtl/movegen_dest_scan.sv ====
module movegen_dest_scan (
  input  logic                               clk,
  input  logic                               i_rst_n,
  input  logic                               i_start,
  input  logic [movegen_pkg::NUM_SQUARES-1:0] i_targets,
  output movegen_pkg::square_t               o_to,
  output logic                               o_gen,
  output logic                               o_piece_done
);

  // the top request is the "no more moves" bit and is always set
  localparam int REQ_W = movegen_pkg::NUM_SQUARES + 1;

  // one-hot base, the scan looks for the first request at or above it
  logic [REQ_W-1:0]   base_q;
  logic [REQ_W-1:0]   req;
  logic [REQ_W-1:0]   grant;

  assign req = {1'b1, i_targets};

  // the usual carry chain bitscan
  // subtracting the base clears the lowest request at or above it and the
  // masking keeps just that bit
  // the done request on top is always found, so the search never has to wrap
  assign grant = req & ~(req - base_q);

  // once every destination has been granted the done bit wins
  assign o_piece_done = grant[REQ_W-1];
  assign o_gen = |grant[REQ_W-2:0];

  // one-hot to binary for the destination square
  always_comb begin
    o_to = '0;
    for (int s = 0; s < movegen_pkg::NUM_SQUARES; s++) begin
      if (grant[s]) begin
        o_to = o_to | movegen_pkg::square_t'(s);
      end
    end
  end

  // step the base to one above the last grant, back to a1 for a new piece
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      base_q <= REQ_W'(1);
    end else if (i_start || o_piece_done) begin
      base_q <= REQ_W'(1);
    end else begin
      base_q <= grant << 1;
    end
  end

endmodule

// ==== rtl/movegen_leaper_targets.sv ====
module movegen_leaper_targets (
  input  movegen_pkg::stack_entry_t          i_head,
  input  movegen_pkg::board_t                i_board,
  input  logic                               i_wtp,
  output logic [movegen_pkg::NUM_SQUARES-1:0] o_targets
);

  // distance between two coordinates on one axis
  function automatic movegen_pkg::rank_t abs_diff(movegen_pkg::rank_t a, movegen_pkg::rank_t b);
    return (a > b) ? movegen_pkg::rank_t'(a - b) : movegen_pkg::rank_t'(b - a);
  endfunction

  movegen_pkg::piece_t piece;
  movegen_pkg::rank_t  from_rank;
  movegen_pkg::rank_t  from_file;
  logic                is_king;
  logic                is_knight;

  assign piece = i_head[8:6];
  assign from_rank = i_head[5:3];
  assign from_file = i_head[2:0];

  // only a real king or knight at the head makes destinations
  assign is_king = i_head[movegen_pkg::ENTRY_FULL] & (piece == movegen_pkg::PIECE_KING);
  assign is_knight = i_head[movegen_pkg::ENTRY_FULL] & (piece == movegen_pkg::PIECE_KNIGHT);

  // every destination works out its own distance to the from square
  // the distances come from true rank and file values, so a move can never
  // wrap around the edge of the board
  always_comb begin
    movegen_pkg::square_t   sq;
    movegen_pkg::rank_t     dr;
    movegen_pkg::rank_t     df;
    movegen_pkg::pos_data_t code;
    logic                   king_hit;
    logic                   knight_hit;
    logic                   own_piece;
    o_targets = '0;
    for (int d = 0; d < movegen_pkg::NUM_SQUARES; d++) begin
      sq = movegen_pkg::square_t'(d);
      dr = abs_diff(sq[5:3], from_rank);
      df = abs_diff(sq[2:0], from_file);
      code = i_board[4*d +: 4];
      // one step in any direction, but not the from square itself
      king_hit = (dr <= 3'd1) && (df <= 3'd1) && ((dr | df) != 3'd0);
      // two along one axis and one along the other
      knight_hit = ((dr == 3'd1) && (df == 3'd2)) || ((dr == 3'd2) && (df == 3'd1));
      // a piece of the side to play blocks the square, an opponent piece can be taken
      own_piece = (code[2:0] != movegen_pkg::PIECE_NONE) &&
                  (code[movegen_pkg::COLOUR_BIT] == i_wtp);
      o_targets[d] = ((is_king & king_hit) | (is_knight & knight_hit)) & ~own_piece;
    end
  end

endmodule

// ==== rtl/movegen_piece_stack.sv ====
module movegen_piece_stack #(
  parameter int STACK_DEPTH = movegen_pkg::STACK_DEPTH_DEFAULT
) (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_pos_valid,
  input  logic                      i_pos_sop,
  input  movegen_pkg::pos_data_t    i_pos_data,
  input  movegen_pkg::square_t      i_square,
  input  logic                      i_wtp,
  input  logic                      i_start,
  input  logic                      i_pop,
  output movegen_pkg::stack_entry_t o_head,
  output logic                      o_more
);

  // colour stacks, index 1 holds the white pieces and index 0 the black ones
  movegen_pkg::stack_entry_t side_q [2][STACK_DEPTH];

  // pieces of the side to play, the head is slot 0
  movegen_pkg::stack_entry_t move_q [STACK_DEPTH];

  logic                      occupied;
  logic                      restart;
  logic [1:0]                push;
  movegen_pkg::stack_entry_t new_entry;

  assign occupied = i_pos_data[2:0] != movegen_pkg::PIECE_NONE;
  assign restart = i_pos_valid & i_pos_sop;

  // an occupied square goes to the stack of its own colour
  assign push[1] = i_pos_valid & occupied & i_pos_data[movegen_pkg::COLOUR_BIT];
  assign push[0] = i_pos_valid & occupied & ~i_pos_data[movegen_pkg::COLOUR_BIT];

  assign new_entry = {1'b1, i_pos_data[2:0], i_square};

  // a push shifts every slot down by one and puts the new piece on top
  // on the first square the old position is thrown away in the same edge
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int c = 0; c < 2; c++) begin
        for (int k = 0; k < STACK_DEPTH; k++) begin
          side_q[c][k] <= '0;
        end
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (restart) begin
          for (int k = 1; k < STACK_DEPTH; k++) begin
            side_q[c][k] <= '0;
          end
          side_q[c][0] <= push[c] ? new_entry : '0;
        end else if (push[c]) begin
          for (int k = 1; k < STACK_DEPTH; k++) begin
            side_q[c][k] <= side_q[c][k-1];
          end
          side_q[c][0] <= new_entry;
        end
      end
    end
  end

  // start copies the whole colour stack in one edge, pop moves on to the next piece
  // a side without any piece gets one full slot holding no piece, so the scan
  // still finishes one piece and the generation ends with eop
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < STACK_DEPTH; k++) begin
        move_q[k] <= '0;
      end
    end else if (i_start) begin
      for (int k = 0; k < STACK_DEPTH; k++) begin
        move_q[k] <= side_q[i_wtp][k];
      end
      if (!side_q[i_wtp][0][movegen_pkg::ENTRY_FULL]) begin
        move_q[0] <= {1'b1, movegen_pkg::PIECE_NONE, movegen_pkg::square_t'(0)};
      end
    end else if (i_pop) begin
      for (int k = 0; k < STACK_DEPTH - 1; k++) begin
        move_q[k] <= move_q[k+1];
      end
      move_q[STACK_DEPTH-1] <= '0;
    end
  end

  assign o_head = move_q[0];

  // another piece waits below the head
  assign o_more = move_q[1][movegen_pkg::ENTRY_FULL];

endmodule

// ==== rtl/movegen_pkg.sv ====
package movegen_pkg;

  // square index is rank times eight plus file, a1 is square 0
  typedef logic [5:0] square_t;

  // a single rank or file coordinate
  typedef logic [2:0] rank_t;

  // piece kind, the same code is used for both colours
  typedef logic [2:0] piece_t;

  // one serial square code, colour in the top bit and the piece kind below it
  typedef logic [3:0] pos_data_t;

  // stack slot laid out as {full, piece, square}
  typedef logic [9:0] stack_entry_t;

  // generated move laid out as {piece, from rank, from file, takes, to rank, to file}
  typedef logic [17:0] uci_move_t;

  // all 64 square codes side by side, square n sits at bits 4n+3 down to 4n
  typedef logic [255:0] board_t;

  localparam int NUM_SQUARES = 64;

  // bit of a square code that is set for a white piece
  localparam int COLOUR_BIT = 3;

  // bit of a stack entry that marks the slot as occupied
  localparam int ENTRY_FULL = 9;

  // piece codes, the rest (queen, rook, bishop, pawn) sit in between and above
  localparam piece_t PIECE_NONE = 3'd0;
  localparam piece_t PIECE_KING = 3'd1;
  localparam piece_t PIECE_KNIGHT = 3'd5;

  // a side rarely holds more than sixteen pieces
  localparam int STACK_DEPTH_DEFAULT = 16;

endpackage

// ==== rtl/movegen_top.sv ====
module movegen_top #(
  parameter int STACK_DEPTH = movegen_pkg::STACK_DEPTH_DEFAULT
) (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_pos_valid,
  input  logic                   i_pos_sop,
  input  movegen_pkg::pos_data_t i_pos_data,
  input  logic                   i_wtp,
  input  logic                   i_start,
  output logic                   o_uci_valid,
  output movegen_pkg::uci_move_t o_uci_data,
  output logic                   o_uci_sop,
  output logic                   o_uci_eop
);

  movegen_pkg::square_t               square;
  movegen_pkg::board_t                board;
  movegen_pkg::stack_entry_t          head;
  logic                               more;
  logic [movegen_pkg::NUM_SQUARES-1:0] targets;
  movegen_pkg::square_t               to_square;
  logic                               gen;
  logic                               piece_done;

  // serial load into the board copy, also numbers the squares for the stacks
  movegen_board_load u_board_load (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_pos_valid (i_pos_valid),
    .i_pos_sop   (i_pos_sop),
    .i_pos_data  (i_pos_data),
    .o_square    (square),
    .o_board     (board)
  );

  // colour stacks fill during the load, the move stack is walked after start
  movegen_piece_stack #(
    .STACK_DEPTH (STACK_DEPTH)
  ) u_piece_stack (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_pos_valid (i_pos_valid),
    .i_pos_sop   (i_pos_sop),
    .i_pos_data  (i_pos_data),
    .i_square    (square),
    .i_wtp       (i_wtp),
    .i_start     (i_start),
    .i_pop       (piece_done),
    .o_head      (head),
    .o_more      (more)
  );

  movegen_leaper_targets u_leaper_targets (
    .i_head    (head),
    .i_board   (board),
    .i_wtp     (i_wtp),
    .o_targets (targets)
  );

  // one destination per cycle, then the done grant pops the next piece
  movegen_dest_scan u_dest_scan (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_start      (i_start),
    .i_targets    (targets),
    .o_to         (to_square),
    .o_gen        (gen),
    .o_piece_done (piece_done)
  );

  movegen_uci_out u_uci_out (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_head       (head),
    .i_more       (more),
    .i_to         (to_square),
    .i_gen        (gen),
    .i_piece_done (piece_done),
    .i_board      (board),
    .o_uci_valid  (o_uci_valid),
    .o_uci_data   (o_uci_data),
    .o_uci_sop    (o_uci_sop),
    .o_uci_eop    (o_uci_eop)
  );

endmodule

// ==== rtl/movegen_uci_out.sv ====
module movegen_uci_out (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  movegen_pkg::stack_entry_t i_head,
  input  logic                      i_more,
  input  movegen_pkg::square_t      i_to,
  input  logic                      i_gen,
  input  logic                      i_piece_done,
  input  movegen_pkg::board_t       i_board,
  output logic                      o_uci_valid,
  output movegen_pkg::uci_move_t    o_uci_data,
  output logic                      o_uci_sop,
  output logic                      o_uci_eop
);

  movegen_pkg::piece_t    takes;
  movegen_pkg::uci_move_t move_word;
  movegen_pkg::uci_move_t buf_data;
  logic                   buf_valid;
  logic                   buf_sop;
  logic                   sop_done;
  logic                   last_done;
  logic                   release_buf;

  // what stands on the destination, none for an empty square
  assign takes = i_board[{i_to, 2'b00} +: 3];
  assign move_word = {i_head[8:6], i_head[5:3], i_head[2:0], takes, i_to[5:3], i_to[2:0]};

  // the last piece of the stack has run out of destinations
  assign last_done = i_head[movegen_pkg::ENTRY_FULL] & ~i_more & i_piece_done;

  // whether a move is the last one is only known later, so moves wait in a
  // one entry buffer until the next move arrives or the generation ends
  assign release_buf = i_gen | last_done;

  always_ff @(posedge clk) begin
    if (i_gen) begin
      buf_data <= move_word;
    end
    o_uci_data <= buf_data;
  end

  // sop_done remembers that the first move of this generation is already out
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      buf_valid <= 1'b0;
      buf_sop <= 1'b0;
      sop_done <= 1'b0;
      o_uci_valid <= 1'b0;
      o_uci_sop <= 1'b0;
      o_uci_eop <= 1'b0;
    end else begin
      if (i_gen) begin
        buf_sop <= ~sop_done;
      end
      if (release_buf) begin
        buf_valid <= i_gen;
        sop_done <= (sop_done | i_gen) & ~last_done;
      end
      // eop rides with the flushed move, or goes out alone if the buffer is empty
      o_uci_valid <= buf_valid & release_buf;
      o_uci_sop <= buf_valid & buf_sop & release_buf;
      o_uci_eop <= last_done;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module movegen_tb -f flist.f
out=$(./obj_dir/Vmovegen_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"
if grep -qx "Regression passed" <<< "$out"; then
  exit 0
fi
exit 1

// ==== test/movegen_props.sv ====
module movegen_props (
  input logic                   clk,
  input logic                   i_rst_n,
  input logic                   i_pos_valid,
  input logic                   i_pos_sop,
  input movegen_pkg::pos_data_t i_pos_data,
  input logic                   i_wtp,
  input logic                   i_start,
  input logic                   i_uci_valid,
  input movegen_pkg::uci_move_t i_uci_data,
  input logic                   i_uci_sop,
  input logic                   i_uci_eop
);

  // true when the code is a piece that belongs to the given side
  function automatic logic holds_side(movegen_pkg::pos_data_t code, logic side);
    return (code[2:0] != movegen_pkg::PIECE_NONE) && (code[movegen_pkg::COLOUR_BIT] == side);
  endfunction

  // king steps one square in any direction, a knight has a rank and file distance product of 2
  function automatic logic leaper_step(movegen_pkg::piece_t piece, int from, int to);
    int dr;
    int df;
    dr = (to / 8) - (from / 8);
    df = (to % 8) - (from % 8);
    dr = (dr < 0) ? -dr : dr;
    df = (df < 0) ? -df : df;
    if (piece == movegen_pkg::PIECE_KING) begin
      return (dr <= 1) && (df <= 1) && (dr + df > 0);
    end
    return (piece == movegen_pkg::PIECE_KNIGHT) && (dr * df == 2);
  endfunction

  // reference board, rebuilt from the load stream
  movegen_pkg::pos_data_t board_m [movegen_pkg::NUM_SQUARES];
  movegen_pkg::square_t   load_sq;
  movegen_pkg::square_t   next_sq_q;
  movegen_pkg::piece_t    mv_piece;
  movegen_pkg::piece_t    mv_takes;
  movegen_pkg::square_t   mv_from;
  movegen_pkg::square_t   mv_to;
  logic                   started_q;
  logic                   in_gen_q;
  logic                   side_q;
  logic                   move_ok;
  int                     exp_count_q;
  int                     seen_count_q;
  int                     fail_count = 0;

  // count of moves the side can make on the reference board
  function automatic int count_moves(logic side);
    int n;
    n = 0;
    for (int s = 0; s < movegen_pkg::NUM_SQUARES; s++) begin
      for (int d = 0; d < movegen_pkg::NUM_SQUARES; d++) begin
        if (holds_side(board_m[s], side) && leaper_step(board_m[s][2:0], s, d) &&
            !holds_side(board_m[d], side)) begin
          n++;
        end
      end
    end
    return n;
  endfunction

  assign load_sq = i_pos_sop ? '0 : next_sq_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      next_sq_q <= '0;
    end else if (i_pos_valid) begin
      next_sq_q <= load_sq + 6'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_pos_valid) begin
      board_m[load_sq] <= i_pos_data;
    end
  end

  // the expected count is taken from the board as it stands when start is sampled
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      started_q <= 1'b0;
      in_gen_q <= 1'b0;
      side_q <= 1'b0;
      exp_count_q <= 0;
      seen_count_q <= 0;
    end else if (i_start) begin
      started_q <= 1'b1;
      in_gen_q <= 1'b1;
      side_q <= i_wtp;
      exp_count_q <= count_moves(i_wtp);
      seen_count_q <= 0;
    end else begin
      if (i_uci_valid) begin
        seen_count_q <= seen_count_q + 1;
      end
      if (i_uci_eop) begin
        in_gen_q <= 1'b0;
      end
    end
  end

  // rank and file side by side already form the square index
  assign mv_piece = i_uci_data[17:15];
  assign mv_from = i_uci_data[14:9];
  assign mv_takes = i_uci_data[8:6];
  assign mv_to = i_uci_data[5:0];

  // own piece on the from square, a leaper step, and no own piece on the destination
  assign move_ok = in_gen_q && holds_side(board_m[mv_from], side_q) &&
                   (board_m[mv_from][2:0] == mv_piece) &&
                   leaper_step(mv_piece, int'(mv_from), int'(mv_to)) &&
                   !holds_side(board_m[mv_to], side_q);

  a_idle_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
    !started_q |-> !(i_uci_valid || i_uci_sop || i_uci_eop))
    else begin
      fail_count++;
      $error("output strobe seen before the first start");
    end

  a_move_legal: assert property (@(posedge clk) disable iff (!i_rst_n) i_uci_valid |-> move_ok)
    else begin
      fail_count++;
      $error("illegal move from square %0d to square %0d", mv_from, mv_to);
    end

  a_takes: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_uci_valid |-> mv_takes == board_m[mv_to][2:0])
    else begin
      fail_count++;
      $error("Error takes_field: expected %0d, actual %0d", board_m[mv_to][2:0], mv_takes);
    end

  // sop marks the first move and nothing else
  a_sop: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_uci_sop == (i_uci_valid && seen_count_q == 0))
    else begin
      fail_count++;
      $error("sop not on the first move of a generation");
    end

  a_eop: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_uci_eop |-> in_gen_q && (exp_count_q == 0 || i_uci_valid))
    else begin
      fail_count++;
      $error("eop outside a generation or apart from the last move");
    end

  a_move_count: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_uci_eop |-> seen_count_q + int'(i_uci_valid) == exp_count_q)
    else begin
      fail_count++;
      $error("Error move_count: expected %0d, actual %0d", exp_count_q,
             seen_count_q + int'(i_uci_valid));
    end

endmodule

// ==== test/movegen_tb.sv ====
module movegen_tb;

  localparam int PERIOD = 4;
  localparam int NUM_POSITIONS = 64;
  localparam int GEN_CYCLES = 40;
  localparam movegen_pkg::piece_t PIECE_PAWN = 3'd6;
  // each position loads 64 squares and then generates, doubled for margin
  localparam int WATCHDOG = NUM_POSITIONS * (movegen_pkg::NUM_SQUARES + GEN_CYCLES) * PERIOD * 2;

  logic clk = 1'b0;
  logic i_rst_n;
  logic i_pos_valid;
  logic i_pos_sop;
  logic i_wtp;
  logic i_start;
  logic o_uci_valid;
  logic o_uci_sop;
  logic o_uci_eop;
  movegen_pkg::pos_data_t i_pos_data;
  movegen_pkg::uci_move_t o_uci_data;
  movegen_pkg::pos_data_t position [movegen_pkg::NUM_SQUARES];
  int seed = 8043;
  int timeouts = 0;

  movegen_top #(.STACK_DEPTH(movegen_pkg::STACK_DEPTH_DEFAULT)) u_movegen_top (.*);

  bind movegen_top movegen_props u_props (
    .clk(clk), .i_rst_n(i_rst_n), .i_pos_valid(i_pos_valid), .i_pos_sop(i_pos_sop),
    .i_pos_data(i_pos_data), .i_wtp(i_wtp), .i_start(i_start),
    .i_uci_valid(o_uci_valid), .i_uci_data(o_uci_data),
    .i_uci_sop(o_uci_sop), .i_uci_eop(o_uci_eop)
  );

  always #(PERIOD / 2) clk = ~clk;

  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    return int'($unsigned(r) % $unsigned(n));
  endfunction

  // drop pieces of one kind and colour on random empty squares
  task automatic place_pieces(movegen_pkg::pos_data_t code, int count);
    int sq;
    for (int k = 0; k < count; k++) begin
      do begin
        sq = rand_below(movegen_pkg::NUM_SQUARES);
      end while (position[sq] != '0);
      position[sq] = code;
    end
  endtask

  // a side may end up with no piece at all, which gives the lone eop case
  task automatic build_position();
    for (int s = 0; s < movegen_pkg::NUM_SQUARES; s++) begin
      position[s] = '0;
    end
    for (int c = 0; c < 2; c++) begin
      place_pieces({c[0], movegen_pkg::PIECE_KING}, rand_below(2));
      place_pieces({c[0], movegen_pkg::PIECE_KNIGHT}, rand_below(3));
      place_pieces({c[0], PIECE_PAWN}, rand_below(5));
    end
  endtask

  task automatic load_position();
    for (int s = 0; s < movegen_pkg::NUM_SQUARES; s++) begin
      @(negedge clk);
      i_pos_valid = 1'b1;
      i_pos_sop = (s == 0);
      i_pos_data = position[s];
    end
    @(negedge clk);
    i_pos_valid = 1'b0;
    i_pos_sop = 1'b0;
  endtask

  // start one generation and wait for its eop
  task automatic run_side(logic side);
    int waited;
    i_wtp = side;
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    waited = 0;
    while (!o_uci_eop && waited < 2 * GEN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!o_uci_eop) begin
      $display("timeout: no eop within %0d cycles for side %0d", waited, side);
      timeouts++;
    end
  endtask

  task automatic finish_run();
    int failures;
    failures = u_movegen_top.u_props.fail_count + timeouts;
    $display("assertion failures: %0d, timeouts: %0d", u_movegen_top.u_props.fail_count,
             timeouts);
    if (failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_pos_valid = 1'b0;
    i_pos_sop = 1'b0;
    i_pos_data = '0;
    i_wtp = 1'b0;
    i_start = 1'b0;
    repeat (5) @(negedge clk);
    i_rst_n = 1'b1;
    // a few quiet cycles after reset before the first load
    repeat (3) @(negedge clk);
    for (int p = 0; p < NUM_POSITIONS && timeouts == 0; p++) begin
      build_position();
      load_position();
      run_side(1'b1);
      run_side(1'b0);
    end
    finish_run();
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired before the last position was done");
    timeouts++;
    finish_run();
  end

endmodule
